/* bench/exec_tb.sv */
`timescale 1ns/1ps
`include "exec_consts.svh"

module exec_tb;

  localparam int WAIT_LIMIT = 100;

  logic                   clk_i;
  logic                   reset_i;
  logic                   req_i;
  exec_pkg::exec_op_t     op_i;
  logic                   ack_o;
  exec_pkg::exec_result_t result_o;

  logic [`XLEN_W-1:0]     model_regs [`NUM_REGS];
  exec_pkg::exec_result_t expected_q [$];
  exec_pkg::exec_result_t exp_res;
  logic                   ack_prev;
  int                     seed = 58127;
  int                     errors;
  int                     checks;
  bit                     timed_out;

  exec_top dut (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (req_i),
    .op_i     (op_i),
    .ack_o    (ack_o),
    .result_o (result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] model_result(input exec_pkg::exec_op_e code,
                                               input logic [31:0] a, input logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] ub;
    logic [63:0]        prod_ss;
    logic [63:0]        prod_su;
    logic [63:0]        prod_uu;
    logic signed [31:0] sra;
    logic signed [31:0] quot_s;
    logic signed [31:0] rem_s;
    logic               overflow;
    logic [31:0]        res;
    sa       = {{32{a[31]}}, a};
    sb       = {{32{b[31]}}, b};
    ub       = {32'b0, b};
    prod_ss  = sa * sb;
    prod_su  = sa * ub;
    prod_uu  = {32'b0, a} * {32'b0, b};
    sra      = $signed(a) >>> b[4:0];
    // most negative over minus one
    overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    // signed quotient and remainder only where they are defined
    if (b != 32'd0 && !overflow) begin
      quot_s = $signed(a) / $signed(b);
      rem_s  = $signed(a) % $signed(b);
    end else begin
      quot_s = '0;
      rem_s  = '0;
    end
    case (code)
      exec_pkg::OP_ADD:    res = a + b;
      exec_pkg::OP_SUB:    res = a - b;
      exec_pkg::OP_SLL:    res = a << b[4:0];
      exec_pkg::OP_SLT:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      exec_pkg::OP_SLTU:   res = (a < b) ? 32'd1 : 32'd0;
      exec_pkg::OP_XOR:    res = a ^ b;
      exec_pkg::OP_SRL:    res = a >> b[4:0];
      exec_pkg::OP_SRA:    res = sra;
      exec_pkg::OP_OR:     res = a | b;
      exec_pkg::OP_AND:    res = a & b;
      exec_pkg::OP_MUL:    res = prod_ss[31:0];
      exec_pkg::OP_MULH:   res = prod_ss[63:32];
      exec_pkg::OP_MULHSU: res = prod_su[63:32];
      exec_pkg::OP_MULHU:  res = prod_uu[63:32];
      exec_pkg::OP_DIV:    res = (b == 0) ? 32'hffff_ffff : overflow ? a : quot_s;
      exec_pkg::OP_DIVU:   res = (b == 0) ? 32'hffff_ffff : a / b;
      exec_pkg::OP_REM:    res = (b == 0) ? a : overflow ? 32'd0 : rem_s;
      exec_pkg::OP_REMU:   res = (b == 0) ? a : a % b;
      default:             res = 32'd0;
    endcase
    return res;
  endfunction

  function automatic exec_pkg::exec_op_t make_op(input exec_pkg::exec_op_e code,
                                                 input logic [4:0] rd, input logic [4:0] rs1,
                                                 input logic [4:0] rs2, input logic use_imm,
                                                 input logic [31:0] imm);
    exec_pkg::exec_op_t op;
    op.op      = code;
    op.rd      = rd;
    op.rs1     = rs1;
    op.rs2     = rs2;
    op.use_imm = use_imm;
    op.imm     = imm;
    return op;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////////////////////

  // counts edges until ack_o reaches level
  task automatic wait_ack(input logic level, input string what, output int edges);
    edges = 0;
    while (ack_o !== level && !timed_out) begin
      @(posedge clk_i);
      #1;
      edges++;
      if (edges >= WAIT_LIMIT && ack_o !== level) begin
        timed_out = 1'b1;
        errors++;
        $display("timeout at %0t: ack_o did not %s", $time, what);
      end
    end
  endtask

  // starts and ends 1 ns after a rising edge
  task automatic run_op(input exec_pkg::exec_op_t op, input int hold_cycles,
                        input bit check_latency);
    logic [31:0]            a;
    logic [31:0]            b;
    exec_pkg::exec_result_t exp;
    int                     edges;
    if (timed_out) return;
    a        = model_regs[op.rs1];
    b        = (op.use_imm && op.op < exec_pkg::OP_MUL) ? op.imm : model_regs[op.rs2];
    exp.rd   = op.rd;
    exp.data = model_result(op.op, a, b);
    expected_q.push_back(exp);
    op_i  = op;
    req_i = 1'b1;
    wait_ack(1'b1, "rise", edges);
    if (timed_out) return;
    // first edge only samples req_i
    if (check_latency) check_value("ack_o latency", 32'(edges - 1), 32'd2);
    repeat (hold_cycles) begin
      @(posedge clk_i);
      #1;
      check_value("ack_o", 32'(ack_o), 32'd1);
      check_value("result_o.data", result_o.data, exp.data);
      check_value("result_o.rd", 32'(result_o.rd), 32'(exp.rd));
    end
    req_i = 1'b0;
    wait_ack(1'b0, "fall", edges);
    if (timed_out) return;
    check_value("ack_o fall delay", 32'(edges), 32'd1);
    if (op.rd != '0) model_regs[op.rd] = exp.data;
  endtask

  task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
    run_op(make_op(exec_pkg::OP_ADD, rd, 5'd0, 5'd0, 1'b1, value), 0, 1'b1);
  endtask

  // result check on each rising ack_o, sampled mid-cycle
  always @(negedge clk_i) begin
    if (ack_o === 1'b1 && ack_prev !== 1'b1) begin
      if (expected_q.size() == 0) begin
        errors++;
        $display("ack_o rose at %0t with no operation outstanding", $time);
      end else begin
        exp_res = expected_q.pop_front();
        check_value("result_o.data", result_o.data, exp_res.data);
        check_value("result_o.rd", 32'(result_o.rd), 32'(exp_res.rd));
      end
    end
    ack_prev = ack_o;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rnd;
    int          k;
    reset_i   = 1'b1;
    req_i     = 1'b0;
    op_i      = '0;
    errors    = 0;
    checks    = 0;
    timed_out = 1'b0;
    ack_prev  = 1'b0;
    for (int i = 0; i < `NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // fresh registers all read zero
    check_value("ack_o", 32'(ack_o), 32'd0);
    run_op(make_op(exec_pkg::OP_ADD, 5'd3, 5'd1, 5'd2, 1'b0, '0), 0, 1'b1);

    for (int r = 1; r <= 8; r++) begin
      rnd = $random(seed);
      load_reg(5'(r), rnd);
    end
    load_reg(5'd9, 32'h8000_0000);
    for (k = exec_pkg::OP_ADD; k <= exec_pkg::OP_AND; k++) begin
      rnd = $random(seed);
      run_op(make_op(exec_pkg::exec_op_e'(k), 5'd11, 5'd1, 5'd2, 1'b0, '0), 0, 1'b1);
      run_op(make_op(exec_pkg::exec_op_e'(k), 5'd12, 5'd9, 5'd0, 1'b1, rnd), 0, 1'b1);
    end
    repeat (40) begin
      rnd = $random(seed);
      run_op(make_op(exec_pkg::exec_op_e'(rnd[7:0] % 10), 5'(1 + rnd[15:8] % 15),
                     5'(rnd[20:16]), 5'(rnd[25:21]), rnd[26], $random(seed)), 0, 1'b1);
    end

    // M extension, random and corner operands
    repeat (4) begin
      load_reg(5'd20, $random(seed));
      load_reg(5'd21, $random(seed));
      for (k = exec_pkg::OP_MUL; k <= exec_pkg::OP_REMU; k++) begin
        run_op(make_op(exec_pkg::exec_op_e'(k), 5'd22, 5'd20, 5'd21, 1'b0, '0), 0, 1'b0);
      end
    end
    load_reg(5'd23, 32'd0);
    load_reg(5'd24, 32'h8000_0000);
    load_reg(5'd25, 32'hffff_ffff);
    for (k = exec_pkg::OP_MUL; k <= exec_pkg::OP_REMU; k++) begin
      run_op(make_op(exec_pkg::exec_op_e'(k), 5'd22, 5'd20, 5'd23, 1'b0, '0), 0, 1'b0);
      run_op(make_op(exec_pkg::exec_op_e'(k), 5'd22, 5'd24, 5'd25, 1'b0, '0), 0, 1'b0);
      run_op(make_op(exec_pkg::exec_op_e'(k), 5'd22, 5'd25, 5'd24, 1'b0, '0), 0, 1'b0);
    end

    // x0 keeps zero
    run_op(make_op(exec_pkg::OP_ADD, 5'd0, 5'd0, 5'd0, 1'b1, 32'h1234_abcd), 0, 1'b1);
    run_op(make_op(exec_pkg::OP_OR, 5'd26, 5'd0, 5'd0, 1'b0, '0), 0, 1'b1);

    // back-pressure on both kinds of operation
    run_op(make_op(exec_pkg::OP_XOR, 5'd27, 5'd1, 5'd2, 1'b0, '0), 5, 1'b1);
    run_op(make_op(exec_pkg::OP_MULH, 5'd28, 5'd3, 5'd4, 1'b0, '0), 4, 1'b0);

    @(posedge clk_i);
    #1;
    if (expected_q.size() != 0) begin
      errors++;
      $display("%0d results were never acknowledged", expected_q.size());
    end
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* include/exec_consts.svh */
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// integer datapath width
`define XLEN_W 32

// register file geometry
`define REG_BITS 5
`define NUM_REGS 32

// one multiply or divide step per cycle
`define MULDIV_STEPS 32

// wide enough to hold MULDIV_STEPS itself
`define STEP_BITS 6

`endif

/* list.f */
+incdir+include
logic/exec_pkg.sv
logic/muldiv_step_counter.sv
logic/reg_file.sv
logic/int_alu.sv
logic/muldiv_datapath.sv
logic/exec_sequencer.sv
logic/exec_top.sv
bench/exec_tb.sv

/* logic/exec_pkg.sv */
`include "exec_consts.svh"

package exec_pkg;

  // opcodes handed in by the requester, already decoded
  typedef enum logic [4:0] {
    OP_ADD,
    OP_SUB,
    OP_SLL,
    OP_SLT,
    OP_SLTU,
    OP_XOR,
    OP_SRL,
    OP_SRA,
    OP_OR,
    OP_AND,
    OP_MUL,
    OP_MULH,
    OP_MULHSU,
    OP_MULHU,
    OP_DIV,
    OP_DIVU,
    OP_REM,
    OP_REMU
  } exec_op_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_EXEC,
    ST_MULDIV,
    ST_WRITE,
    ST_ACK
  } seq_state_e;

  // one operation as seen on op_i
  typedef struct packed {
    exec_op_e             op;
    logic [`REG_BITS-1:0] rd;
    logic [`REG_BITS-1:0] rs1;
    logic [`REG_BITS-1:0] rs2;
    logic                 use_imm;
    logic [`XLEN_W-1:0]   imm;
  } exec_op_t;

  typedef struct packed {
    logic [`REG_BITS-1:0] rd;
    logic [`XLEN_W-1:0]   data;
  } exec_result_t;

endpackage

/* logic/exec_sequencer.sv */
`timescale 1ns/1ps
`include "exec_consts.svh"

module exec_sequencer (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   req_i,
  input  exec_pkg::exec_op_t     op_i,
  input  logic [`XLEN_W-1:0]     alu_result_i,
  input  logic [`XLEN_W-1:0]     muldiv_result_i,
  input  logic                   last_step_i,
  output logic                   muldiv_start_o,
  output logic                   count_en_o,
  output logic                   wr_en_o,
  output exec_pkg::exec_result_t wr_o,
  output logic                   ack_o,
  output exec_pkg::exec_result_t result_o
);

  exec_pkg::seq_state_e   state_q;
  exec_pkg::seq_state_e   state_d;
  exec_pkg::exec_op_t     op_q;
  exec_pkg::exec_result_t res_q;
  logic                   ack_q;
  logic                   steps_done_q;
  logic                   is_muldiv;

  always_comb begin
    case (op_q.op)
      exec_pkg::OP_MUL, exec_pkg::OP_MULH, exec_pkg::OP_MULHSU, exec_pkg::OP_MULHU,
      exec_pkg::OP_DIV, exec_pkg::OP_DIVU, exec_pkg::OP_REM, exec_pkg::OP_REMU: begin
        is_muldiv = 1'b1;
      end
      default: begin
        is_muldiv = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // handshake FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      exec_pkg::ST_IDLE: begin
        if (req_i) begin
          state_d = exec_pkg::ST_EXEC;
        end
      end
      exec_pkg::ST_EXEC: begin
        state_d = is_muldiv ? exec_pkg::ST_MULDIV : exec_pkg::ST_WRITE;
      end
      exec_pkg::ST_MULDIV: begin
        // one extra cycle after the last step to capture the result
        if (steps_done_q) begin
          state_d = exec_pkg::ST_WRITE;
        end
      end
      exec_pkg::ST_WRITE: begin
        state_d = exec_pkg::ST_ACK;
      end
      exec_pkg::ST_ACK: begin
        if (!req_i) begin
          state_d = exec_pkg::ST_IDLE;
        end
      end
      default: begin
        state_d = exec_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q      <= exec_pkg::ST_IDLE;
      ack_q        <= 1'b0;
      steps_done_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      steps_done_q <= count_en_o & last_step_i;
      if (state_q == exec_pkg::ST_WRITE) begin
        ack_q <= 1'b1;
      end else if (state_q == exec_pkg::ST_ACK && !req_i) begin
        ack_q <= 1'b0;
      end
    end
  end

  // operation and result payload
  always_ff @(posedge clk_i) begin
    if (state_q == exec_pkg::ST_IDLE && req_i) begin
      op_q <= op_i;
    end
    if (state_q == exec_pkg::ST_EXEC) begin
      res_q.rd   <= op_q.rd;
      res_q.data <= alu_result_i;
    end else if (state_q == exec_pkg::ST_MULDIV && steps_done_q) begin
      res_q.data <= muldiv_result_i;
    end
  end

  assign muldiv_start_o = (state_q == exec_pkg::ST_EXEC) && is_muldiv;
  assign count_en_o     = (state_q == exec_pkg::ST_MULDIV) && !steps_done_q;
  assign wr_en_o        = (state_q == exec_pkg::ST_WRITE);
  assign wr_o           = res_q;
  assign result_o       = res_q;
  assign ack_o          = ack_q;

  // requester must drop req before the ack may go away
  assert property (@(posedge clk_i) disable iff (reset_i)
    (ack_q && req_i) |=> ack_q);

  assert property (@(posedge clk_i) disable iff (reset_i)
    (state_q == exec_pkg::ST_IDLE) |-> !ack_q);

endmodule

/* logic/exec_top.sv */
`timescale 1ns/1ps
`include "exec_consts.svh"

module exec_top (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   req_i,
  input  exec_pkg::exec_op_t     op_i,
  output logic                   ack_o,
  output exec_pkg::exec_result_t result_o
);

  logic [`XLEN_W-1:0]     rs1_data;
  logic [`XLEN_W-1:0]     rs2_data;
  logic [`XLEN_W-1:0]     operand_b;
  logic [`XLEN_W-1:0]     alu_result;
  logic [`XLEN_W-1:0]     muldiv_result;
  logic                   muldiv_start;
  logic                   count_en;
  logic                   last_step;
  logic                   wr_en;
  exec_pkg::exec_result_t wr;

  // op_i is held for the whole exchange so operands come straight from it
  assign operand_b = op_i.use_imm ? op_i.imm : rs2_data;

  exec_sequencer u_sequencer (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req_i           (req_i),
    .op_i            (op_i),
    .alu_result_i    (alu_result),
    .muldiv_result_i (muldiv_result),
    .last_step_i     (last_step),
    .muldiv_start_o  (muldiv_start),
    .count_en_o      (count_en),
    .wr_en_o         (wr_en),
    .wr_o            (wr),
    .ack_o           (ack_o),
    .result_o        (result_o)
  );

  // counter restarts together with the datapath
  muldiv_step_counter u_step_counter (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .load_i      (muldiv_start),
    .en_i        (count_en),
    .last_step_o (last_step)
  );

  reg_file u_reg_file (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rs1_addr_i (op_i.rs1),
    .rs2_addr_i (op_i.rs2),
    .rs1_o      (rs1_data),
    .rs2_o      (rs2_data),
    .wr_en_i    (wr_en),
    .wr_i       (wr)
  );

  int_alu u_alu (
    .op_i     (op_i.op),
    .a_i      (rs1_data),
    .b_i      (operand_b),
    .result_o (alu_result)
  );

  // M extension always works on two registers
  muldiv_datapath u_muldiv (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .start_i  (muldiv_start),
    .step_i   (count_en),
    .op_i     (op_i.op),
    .a_i      (rs1_data),
    .b_i      (rs2_data),
    .result_o (muldiv_result)
  );

endmodule

/* logic/int_alu.sv */
`timescale 1ns/1ps
`include "exec_consts.svh"

module int_alu (
  input  exec_pkg::exec_op_e   op_i,
  input  logic [`XLEN_W-1:0]   a_i,
  input  logic [`XLEN_W-1:0]   b_i,
  output logic [`XLEN_W-1:0]   result_o
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b_i[4:0];
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb begin
    case (op_i)
      exec_pkg::OP_ADD: begin
        result_o = a_i + b_i;
      end
      exec_pkg::OP_SUB: begin
        result_o = a_i - b_i;
      end
      exec_pkg::OP_SLL: begin
        result_o = a_i << shamt;
      end
      // compares give 0 or 1
      exec_pkg::OP_SLT: begin
        result_o = {{(`XLEN_W-1){1'b0}}, lt_signed};
      end
      exec_pkg::OP_SLTU: begin
        result_o = {{(`XLEN_W-1){1'b0}}, lt_unsigned};
      end
      exec_pkg::OP_XOR: begin
        result_o = a_i ^ b_i;
      end
      exec_pkg::OP_SRL: begin
        result_o = a_i >> shamt;
      end
      exec_pkg::OP_SRA: begin
        result_o = $unsigned($signed(a_i) >>> shamt);
      end
      exec_pkg::OP_OR: begin
        result_o = a_i | b_i;
      end
      exec_pkg::OP_AND: begin
        result_o = a_i & b_i;
      end
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule

/* logic/muldiv_datapath.sv */
`timescale 1ns/1ps
`include "exec_consts.svh"

module muldiv_datapath (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 start_i,
  input  logic                 step_i,
  input  exec_pkg::exec_op_e   op_i,
  input  logic [`XLEN_W-1:0]   a_i,
  input  logic [`XLEN_W-1:0]   b_i,
  output logic [`XLEN_W-1:0]   result_o
);

  localparam int W = `XLEN_W;

  exec_pkg::exec_op_e op_q;
  logic               a_neg_q;
  logic               b_neg_q;
  logic               b_zero_q;
  logic [W-1:0]       hi_q;
  logic [W-1:0]       lo_q;
  logic [W-1:0]       b_mag_q;

  logic               a_signed;
  logic               b_signed;
  logic               a_neg;
  logic               b_neg;
  logic [W-1:0]       a_mag;
  logic [W-1:0]       b_mag;
  logic               is_div;
  logic [W:0]         add_sum;
  logic [W:0]         shifted;
  logic [W+1:0]       diff;
  logic [2*W-1:0]     product;
  logic [2*W-1:0]     prod_fix;
  logic [W-1:0]       quot_fix;
  logic [W-1:0]       rem_fix;

  ////////////////////////////////////////////////////////////////////////////
  // operand setup
  ////////////////////////////////////////////////////////////////////////////

  // MUL low word is the same either way so it runs unsigned
  always_comb begin
    case (op_i)
      exec_pkg::OP_MULH, exec_pkg::OP_DIV, exec_pkg::OP_REM: begin
        a_signed = 1'b1;
        b_signed = 1'b1;
      end
      exec_pkg::OP_MULHSU: begin
        a_signed = 1'b1;
        b_signed = 1'b0;
      end
      default: begin
        a_signed = 1'b0;
        b_signed = 1'b0;
      end
    endcase
  end

  assign a_neg = a_signed & a_i[W-1];
  assign b_neg = b_signed & b_i[W-1];
  assign a_mag = a_neg ? -a_i : a_i;
  assign b_mag = b_neg ? -b_i : b_i;

  assign is_div = (op_q == exec_pkg::OP_DIV) || (op_q == exec_pkg::OP_DIVU) ||
                  (op_q == exec_pkg::OP_REM) || (op_q == exec_pkg::OP_REMU);

  ////////////////////////////////////////////////////////////////////////////
  // iteration
  ////////////////////////////////////////////////////////////////////////////

  // shift-add: multiplier sits in lo_q and drains out the bottom
  assign add_sum = {1'b0, hi_q} + (lo_q[0] ? {1'b0, b_mag_q} : '0);

  // restoring divide: remainder in hi_q and quotient bits enter lo_q
  assign shifted = {hi_q, lo_q[W-1]};
  assign diff    = {1'b0, shifted} - {2'b00, b_mag_q};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      op_q     <= exec_pkg::OP_ADD;
      a_neg_q  <= 1'b0;
      b_neg_q  <= 1'b0;
      b_zero_q <= 1'b0;
    end else if (start_i) begin
      op_q     <= op_i;
      a_neg_q  <= a_neg;
      b_neg_q  <= b_neg;
      b_zero_q <= (b_i == '0);
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      hi_q    <= '0;
      lo_q    <= a_mag;
      b_mag_q <= b_mag;
    end else if (step_i) begin
      if (!is_div) begin
        hi_q <= add_sum[W:1];
        lo_q <= {add_sum[0], lo_q[W-1:1]};
      end else if (diff[W+1]) begin
        hi_q <= shifted[W-1:0];
        lo_q <= {lo_q[W-2:0], 1'b0};
      end else begin
        hi_q <= diff[W-1:0];
        lo_q <= {lo_q[W-2:0], 1'b1};
      end
    end
  end

  // sign fix-up on the magnitudes
  assign product  = {hi_q, lo_q};
  assign prod_fix = (a_neg_q ^ b_neg_q) ? -product : product;
  // x/0 leaves all ones in the quotient, which must not be negated
  assign quot_fix = ((a_neg_q ^ b_neg_q) && !b_zero_q) ? -lo_q : lo_q;
  assign rem_fix  = a_neg_q ? -hi_q : hi_q;

  always_comb begin
    case (op_q)
      exec_pkg::OP_MUL: begin
        result_o = prod_fix[W-1:0];
      end
      exec_pkg::OP_MULH, exec_pkg::OP_MULHSU, exec_pkg::OP_MULHU: begin
        result_o = prod_fix[2*W-1:W];
      end
      exec_pkg::OP_DIV, exec_pkg::OP_DIVU: begin
        result_o = quot_fix;
      end
      exec_pkg::OP_REM, exec_pkg::OP_REMU: begin
        result_o = rem_fix;
      end
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule

/* logic/muldiv_step_counter.sv */
`timescale 1ns/1ps
`include "exec_consts.svh"

module muldiv_step_counter (
  input  logic clk_i,
  input  logic reset_i,
  input  logic load_i,
  input  logic en_i,
  output logic last_step_o
);

  localparam logic [`STEP_BITS-1:0] MAX_COUNT  = `STEP_BITS'(`MULDIV_STEPS);
  localparam logic [`STEP_BITS-1:0] LAST_COUNT = `STEP_BITS'(`MULDIV_STEPS - 1);

  logic [`STEP_BITS-1:0] count_q;

  // stops at MAX_COUNT instead of wrapping
  always_ff @(posedge clk_i) begin
    if (reset_i || load_i) begin
      count_q <= '0;
    end else if (en_i && count_q < MAX_COUNT) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign last_step_o = (count_q == LAST_COUNT);

  // no step may be requested once all steps have run
  assert property (@(posedge clk_i) disable iff (reset_i)
    en_i |-> (count_q < MAX_COUNT));

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ps
`include "exec_consts.svh"

module reg_file (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic [`REG_BITS-1:0]   rs1_addr_i,
  input  logic [`REG_BITS-1:0]   rs2_addr_i,
  output logic [`XLEN_W-1:0]     rs1_o,
  output logic [`XLEN_W-1:0]     rs2_o,
  input  logic                   wr_en_i,
  input  exec_pkg::exec_result_t wr_i
);

  logic [`XLEN_W-1:0] regs_q [`NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && wr_i.rd != '0) begin
      // x0 is hard-wired, drop the write
      regs_q[wr_i.rd] <= wr_i.data;
    end
  end

  // asynchronous read ports
  assign rs1_o = regs_q[rs1_addr_i];
  assign rs2_o = regs_q[rs2_addr_i];

  assert property (@(posedge clk_i) disable iff (reset_i)
    regs_q[0] == '0);

endmodule

/* run_sim.sh */
#!/bin/sh
# builds the exec_top testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=exec_tb_sim

if ! verilator --binary --timing --assert -Wno-fatal -f list.f --top-module exec_tb -o "$BIN"; then
  echo "verilator compile step failed"
  exit 1
fi

if ! ./obj_dir/"$BIN" > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error status"
  exit 1
fi

cat "$LOG"

if grep -q "^all tests passed$" "$LOG"; then
  echo "RESULT: PASS"
  exit 0
fi

echo "RESULT: FAIL"
exit 1
